// File: panel_pkg.sv
/* Panel geometry, pixel format and the address and field widths derived from them */
`default_nettype none

package panel_pkg;

    // ********************
    // Panel geometry
    localparam int num_rows    = 32;
    localparam int num_columns = 64;
    localparam int row_bits    = $clog2(num_rows);
    localparam int column_bits = $clog2(num_columns);

    // Column values travel as whole bytes, most significant byte first
    localparam int column_bytes = (column_bits + 8 - 1) / 8;
    localparam int column_byte_count_bits = (column_bytes > 1) ? $clog2(column_bytes) : 1;

    // Captured field widths, wide enough to see a rectangle run off the panel
    localparam int column_field_bits = column_bytes * 8;
    localparam int row_field_bits    = 8;

    // ********************
    // Pixel format
    localparam int bytes_per_pixel   = 3;
    localparam int pixel_select_bits = $clog2(bytes_per_pixel);
    // Red sits in the top byte and goes out with the highest pixel select
    localparam int color_bits        = bytes_per_pixel * 8;

    // x1, y1, width, height, then the colour
    localparam int cmd_arg_bytes = 2 * column_bytes + 2 + bytes_per_pixel;

    // ********************
    // Frame memory
    localparam int ram_depth     = num_rows * num_columns * bytes_per_pixel;
    localparam int ram_addr_bits = row_bits + column_bits + pixel_select_bits;

endpackage

`default_nettype wire

// File: fillarea_walker.sv
/* Rectangle walker: clips the area at the panel edge and writes one pixel byte per cycle */
`default_nettype none

module fillarea_walker import panel_pkg::*; (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          start,
    input  wire  [column_field_bits-1:0] x1,
    input  wire  [row_field_bits-1:0]    y1,
    input  wire  [column_field_bits-1:0] width,
    input  wire  [row_field_bits-1:0]    height,
    input  wire  [color_bits-1:0]        color,
    output logic [row_bits-1:0]          row,
    output logic [column_bits-1:0]       column,
    output logic [pixel_select_bits-1:0] pixel,
    output logic [7:0]                   data_out,
    output logic                         ram_write_enable,
    output logic                         walk_done
);

    logic [column_field_bits:0] column_sum;
    logic [row_field_bits:0]    row_sum;
    logic [column_field_bits:0] column_limit;
    logic [row_field_bits:0]    row_limit;
    logic                       area_empty;
    logic [column_bits:0]       column_stop;
    logic [row_bits:0]          row_stop;
    logic [column_bits-1:0]     column_first;
    logic [color_bits-1:0]      color_q;
    logic [column_bits:0]       column_next;
    logic [row_bits:0]          row_next;

    // Exclusive end of the area, clipped to the panel
    always_comb begin
        column_sum = {1'b0, x1} + {1'b0, width};
        row_sum    = {1'b0, y1} + {1'b0, height};
        column_limit = (column_sum > num_columns) ?
                       (column_field_bits + 1)'(num_columns) : column_sum;
        row_limit    = (row_sum > num_rows) ? (row_field_bits + 1)'(num_rows) : row_sum;
        // Covers zero width, zero height and a start point off the panel
        area_empty = (column_limit <= {1'b0, x1}) || (row_limit <= {1'b0, y1});
    end

    assign column_next = {1'b0, column} + 1'b1;
    assign row_next    = {1'b0, row} + 1'b1;
    assign data_out    = color_q[pixel*8 +: 8];

    always_ff @(posedge clk) begin
        if (start) begin
            column_stop  <= column_limit[column_bits:0];
            row_stop     <= row_limit[row_bits:0];
            column_first <= x1[column_bits-1:0];
            color_q      <= color;
        end
    end

    // ********************
    // Row, column and byte counters
    always_ff @(posedge clk) begin
        if (reset) begin
            row              <= '0;
            column           <= '0;
            pixel            <= '0;
            ram_write_enable <= 1'b0;
            walk_done        <= 1'b0;
        end else begin
            walk_done <= 1'b0;
            if (start) begin
                row              <= y1[row_bits-1:0];
                column           <= x1[column_bits-1:0];
                pixel            <= (pixel_select_bits)'(bytes_per_pixel - 1);
                ram_write_enable <= !area_empty;
                walk_done        <= area_empty;
            end else if (ram_write_enable) begin
                if (pixel != '0) begin
                    pixel <= pixel - 1'b1;
                end else begin
                    pixel <= (pixel_select_bits)'(bytes_per_pixel - 1);
                    if (column_next < column_stop) begin
                        column <= column_next[column_bits-1:0];
                    end else if (row_next < row_stop) begin
                        row    <= row_next[row_bits-1:0];
                        column <= column_first;
                    end else begin
                        ram_write_enable <= 1'b0;
                        walk_done        <= 1'b1;
                    end
                end
            end
        end
    end

    // Every write lies inside the area clipped to the panel
    assert property (@(posedge clk) disable iff (reset)
        ram_write_enable |-> ({1'b0, column} < column_stop) && ({1'b0, row} < row_stop));

    // The command block waits for walk_done before it can start again
    assert property (@(posedge clk) disable iff (reset)
        start |-> !ram_write_enable);

endmodule

`default_nettype wire

// File: cmd_fillrect.sv
/* Fill-rectangle command block: captures the argument bytes, runs the area walker,
   then signals done */
`default_nettype none

module cmd_fillrect import panel_pkg::*; (
    input  wire                          clk,
    input  wire                          reset,
    input  wire  [7:0]                   data_in,
    input  wire                          enable,
    output logic                         ready_for_data,
    output logic                         done,
    output logic [row_bits-1:0]          row,
    output logic [column_bits-1:0]       column,
    output logic [pixel_select_bits-1:0] pixel,
    output logic [7:0]                   data_out,
    output logic                         ram_write_enable
);

    typedef enum logic [2:0] {
        state_x1_capture,
        state_y1_capture,
        state_width_capture,
        state_height_capture,
        state_color_capture,
        state_start,
        state_running,
        state_done
    } cmd_state_t;

    cmd_state_t state;

    logic [column_field_bits-1:0]      x1;
    logic [column_field_bits-1:0]      width;
    logic [row_field_bits-1:0]         y1;
    logic [row_field_bits-1:0]         height;
    logic [color_bits-1:0]             color;
    logic [column_byte_count_bits-1:0] x1_byte_count;
    logic [column_byte_count_bits-1:0] width_byte_count;
    logic [pixel_select_bits-1:0]      color_bytes_left;
    logic                              start;
    logic                              walk_done;
    logic                              accept;

    assign accept = enable && ready_for_data;

    // ********************
    // Argument capture and command sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= state_x1_capture;
            ready_for_data   <= 1'b1;
            start            <= 1'b0;
            done             <= 1'b0;
            x1_byte_count    <= (column_byte_count_bits)'(column_bytes - 1);
            width_byte_count <= (column_byte_count_bits)'(column_bytes - 1);
            color_bytes_left <= (pixel_select_bits)'(bytes_per_pixel - 1);
        end else begin
            start <= 1'b0;
            done  <= 1'b0;
            case (state)
                state_x1_capture: begin
                    if (accept) begin
                        x1[x1_byte_count*8 +: 8] <= data_in;
                        if (x1_byte_count == '0) begin
                            state <= state_y1_capture;
                        end else begin
                            x1_byte_count <= x1_byte_count - 1'b1;
                        end
                    end
                end
                state_y1_capture: begin
                    if (accept) begin
                        y1    <= data_in;
                        state <= state_width_capture;
                    end
                end
                state_width_capture: begin
                    if (accept) begin
                        width[width_byte_count*8 +: 8] <= data_in;
                        if (width_byte_count == '0) begin
                            state <= state_height_capture;
                        end else begin
                            width_byte_count <= width_byte_count - 1'b1;
                        end
                    end
                end
                state_height_capture: begin
                    if (accept) begin
                        height <= data_in;
                        state  <= state_color_capture;
                    end
                end
                state_color_capture: begin
                    if (accept) begin
                        color[color_bytes_left*8 +: 8] <= data_in;
                        if (color_bytes_left == '0) begin
                            ready_for_data <= 1'b0;
                            state          <= state_start;
                        end else begin
                            color_bytes_left <= color_bytes_left - 1'b1;
                        end
                    end
                end
                state_start: begin
                    start <= 1'b1;
                    state <= state_running;
                end
                state_running: begin
                    if (walk_done) begin
                        done  <= 1'b1;
                        state <= state_done;
                    end
                end
                state_done: begin
                    // Back to capture, counters ready for the next command
                    ready_for_data   <= 1'b1;
                    x1_byte_count    <= (column_byte_count_bits)'(column_bytes - 1);
                    width_byte_count <= (column_byte_count_bits)'(column_bytes - 1);
                    color_bytes_left <= (pixel_select_bits)'(bytes_per_pixel - 1);
                    state            <= state_x1_capture;
                end
                default: state <= state_x1_capture;
            endcase
        end
    end

    fillarea_walker walker_i (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .x1               (x1),
        .y1               (y1),
        .width            (width),
        .height           (height),
        .color            (color),
        .row              (row),
        .column           (column),
        .pixel            (pixel),
        .data_out         (data_out),
        .ram_write_enable (ram_write_enable),
        .walk_done        (walk_done)
    );

    // No back-pressure, so the host must hold off while a command runs
    assert property (@(posedge clk) disable iff (reset)
        !ready_for_data |-> !enable);

endmodule

`default_nettype wire

// File: frame_ram.sv
/* Byte framebuffer with one write port and a registered scan read port */
`default_nettype none

module frame_ram import panel_pkg::*; (
    input  wire                         clk,
    input  wire [row_bits-1:0]          row,
    input  wire [column_bits-1:0]       column,
    input  wire [pixel_select_bits-1:0] pixel,
    input  wire [7:0]                   wr_data,
    input  wire                         ram_write_enable,
    input  wire [row_bits-1:0]          scan_row,
    input  wire [column_bits-1:0]       scan_column,
    input  wire [pixel_select_bits-1:0] scan_pixel,
    output logic [7:0]                  scan_data
);

    logic [7:0]               mem [ram_depth];
    logic [ram_addr_bits-1:0] wr_addr;
    logic [ram_addr_bits-1:0] rd_addr;

    // Pixels are packed three bytes apart, row-major
    function automatic logic [ram_addr_bits-1:0] byte_addr(
        input logic [row_bits-1:0]          r,
        input logic [column_bits-1:0]       c,
        input logic [pixel_select_bits-1:0] p
    );
        return (ram_addr_bits)'({r, c}) * (ram_addr_bits)'(bytes_per_pixel)
               + (ram_addr_bits)'(p);
    endfunction

    assign wr_addr = byte_addr(row, column, pixel);
    assign rd_addr = byte_addr(scan_row, scan_column, scan_pixel);

    always_ff @(posedge clk) begin
        if (ram_write_enable) begin
            mem[wr_addr] <= wr_data;
        end
        // Old data wins on a same-address collision
        scan_data <= mem[rd_addr];
    end

    assert property (@(posedge clk)
        ram_write_enable |-> (wr_addr != rd_addr));

endmodule

`default_nettype wire

// File: panel_fill_top.sv
/* Top level: fill-rectangle command block feeding the panel framebuffer */
`default_nettype none

module panel_fill_top import panel_pkg::*; (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [7:0]                   data_in,
    input  wire                         enable,
    input  wire [row_bits-1:0]          scan_row,
    input  wire [column_bits-1:0]       scan_column,
    input  wire [pixel_select_bits-1:0] scan_pixel,
    output logic                        ready_for_data,
    output logic                        done,
    output logic [7:0]                  scan_data
);

    // Walker write port into the frame memory
    logic [row_bits-1:0]          row;
    logic [column_bits-1:0]       column;
    logic [pixel_select_bits-1:0] pixel;
    logic [7:0]                   data_out;
    logic                         ram_write_enable;

    cmd_fillrect cmd_i (
        .clk              (clk),
        .reset            (reset),
        .data_in          (data_in),
        .enable           (enable),
        .ready_for_data   (ready_for_data),
        .done             (done),
        .row              (row),
        .column           (column),
        .pixel            (pixel),
        .data_out         (data_out),
        .ram_write_enable (ram_write_enable)
    );

    frame_ram ram_i (
        .clk              (clk),
        .row              (row),
        .column           (column),
        .pixel            (pixel),
        .wr_data          (data_out),
        .ram_write_enable (ram_write_enable),
        .scan_row         (scan_row),
        .scan_column      (scan_column),
        .scan_pixel       (scan_pixel),
        .scan_data        (scan_data)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/* Testbench clock and power-on reset */
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_panel_fill.sv
/* Fill-rectangle testbench: command driver, reference framebuffer model,
   scan-port readback with comparison, and a cycle watchdog */
`default_nettype none

module tb_panel_fill import panel_pkg::*; ();

    localparam int num_commands  = 25;
    localparam int num_readbacks = 24;
    localparam int cycle_limit   = num_commands * (num_rows * num_columns * 3 + 20)
                                   + num_readbacks * (ram_depth + 10) + 100;

    logic                         clk;
    logic                         reset;
    logic [7:0]                   data_in;
    logic                         enable;
    logic [row_bits-1:0]          scan_row;
    logic [column_bits-1:0]       scan_column;
    logic [pixel_select_bits-1:0] scan_pixel;
    logic                         ready_for_data;
    logic                         done;
    logic [7:0]                   scan_data;

    logic [7:0] model [num_rows][num_columns][bytes_per_pixel];
    int         done_count  = 0;
    int         cycle_count = 0;

    tb_clock_gen clock_i (
        .clk   (clk),
        .reset (reset)
    );

    panel_fill_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .enable         (enable),
        .scan_row       (scan_row),
        .scan_column    (scan_column),
        .scan_pixel     (scan_pixel),
        .ready_for_data (ready_for_data),
        .done           (done),
        .scan_data      (scan_data)
    );

    // ********************
    // Reference model
    function automatic void apply_rect(input int x1, input int y1, input int w, input int h,
                                       input logic [color_bits-1:0] color);
        for (int r = y1; r < y1 + h && r < num_rows; r++) begin
            for (int c = x1; c < x1 + w && c < num_columns; c++) begin
                // Pixel select 2 carries red, the top colour byte
                for (int p = 0; p < bytes_per_pixel; p++) begin
                    model[r][c][p] = color[p*8 +: 8];
                end
            end
        end
    endfunction

    function automatic int write_count(input int x1, input int y1, input int w, input int h);
        int cw;
        int ch;
        cw = (x1 >= num_columns) ? 0 : ((x1 + w > num_columns) ? num_columns - x1 : w);
        ch = (y1 >= num_rows) ? 0 : ((y1 + h > num_rows) ? num_rows - y1 : h);
        return cw * ch * bytes_per_pixel;
    endfunction

    // ********************
    // Failure reporting
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s expected %h, got %h", name, expected, actual));
        end
    endtask

    // ********************
    // Command driver with handshake and latency checks
    task automatic run_command(input int x1, input int y1, input int w, input int h,
                               input logic [color_bits-1:0] color);
        logic [7:0] cmd_bytes [$];
        int         expected_writes;
        int         cycles;
        for (int b = column_bytes - 1; b >= 0; b--) cmd_bytes.push_back(8'(x1 >> (8 * b)));
        cmd_bytes.push_back(8'(y1));
        for (int b = column_bytes - 1; b >= 0; b--) cmd_bytes.push_back(8'(w >> (8 * b)));
        cmd_bytes.push_back(8'(h));
        for (int b = bytes_per_pixel - 1; b >= 0; b--) cmd_bytes.push_back(color[b*8 +: 8]);
        expected_writes = write_count(x1, y1, w, h);
        @(negedge clk);
        while (!ready_for_data) @(negedge clk);
        foreach (cmd_bytes[i]) begin
            @(posedge clk);
            data_in <= cmd_bytes[i];
            enable  <= 1'b1;
        end
        // Last byte is taken at this edge
        @(posedge clk);
        enable <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            check_value("ready_for_data", 32'd0, 32'(ready_for_data));
        end while (!done);
        // Cycles before done: ready falls, start, the writes, walk_done
        check_value("done_latency", 32'(expected_writes + 3), 32'(cycles - 1));
        @(negedge clk);
        check_value("done", 32'd0, 32'(done));
        check_value("ready_for_data", 32'd1, 32'(ready_for_data));
        apply_rect(x1, y1, w, h, color);
    endtask

    // Pipelined readback, one address per cycle, data checked one cycle later
    task automatic readback_panel();
        int  r_prev;
        int  c_prev;
        int  p_prev;
        bit  have_prev;
        have_prev = 1'b0;
        r_prev    = 0;
        c_prev    = 0;
        p_prev    = 0;
        for (int r = 0; r < num_rows; r++) begin
            for (int c = 0; c < num_columns; c++) begin
                for (int p = 0; p < bytes_per_pixel; p++) begin
                    @(posedge clk);
                    scan_row    <= (row_bits)'(r);
                    scan_column <= (column_bits)'(c);
                    scan_pixel  <= (pixel_select_bits)'(p);
                    @(negedge clk);
                    if (have_prev) begin
                        check_value($sformatf("scan_data[%0d][%0d][%0d]", r_prev, c_prev, p_prev),
                                    32'(model[r_prev][c_prev][p_prev]), 32'(scan_data));
                    end
                    r_prev    = r;
                    c_prev    = c;
                    p_prev    = p;
                    have_prev = 1'b1;
                end
            end
        end
        park_scan();
        @(negedge clk);
        check_value($sformatf("scan_data[%0d][%0d][%0d]", r_prev, c_prev, p_prev),
                    32'(model[r_prev][c_prev][p_prev]), 32'(scan_data));
    endtask

    // Parked one past the last byte, so the scan port never meets a walker write
    task automatic park_scan();
        @(posedge clk);
        scan_row    <= (row_bits)'(num_rows - 1);
        scan_column <= (column_bits)'(num_columns - 1);
        scan_pixel  <= (pixel_select_bits)'(bytes_per_pixel);
    endtask

    // ********************
    // Handshake monitor and watchdog
    always @(negedge clk) begin
        if (!reset) begin
            if (enable && !ready_for_data) begin
                report_failure("Host strobed enable while the DUT was not ready for data");
            end
            if (done) done_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                     cycle_limit));
        end
    end

    // ********************
    // Test sequence
    initial begin
        data_in     = 8'h00;
        enable      = 1'b0;
        scan_row    = (row_bits)'(num_rows - 1);
        scan_column = (column_bits)'(num_columns - 1);
        scan_pixel  = (pixel_select_bits)'(bytes_per_pixel);
        void'($urandom(32'h5f04));
        @(negedge clk);
        while (reset) @(negedge clk);
        check_value("ready_for_data", 32'd1, 32'(ready_for_data));
        check_value("done", 32'd0, 32'(done));

        run_command(0, 0, num_columns, num_rows, 24'ha1b2c3);
        readback_panel();
        run_command(10, 5, 20, 8, 24'h3c5a96);
        readback_panel();
        // Runs past the right and bottom edges
        run_command(50, 25, 30, 20, 24'he01f77);
        readback_panel();
        run_command(5, 5, 0, 10, 24'h123456);
        run_command(5, 5, 10, 0, 24'h654321);
        readback_panel();

        for (int i = 0; i < 20; i++) begin
            run_command($urandom_range(0, num_columns + 5), $urandom_range(0, num_rows + 3),
                        $urandom_range(0, num_columns), $urandom_range(0, num_rows),
                        24'($urandom));
            readback_panel();
        end

        if (done_count == num_commands) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_failure($sformatf("Error: done_count expected %h, got %h",
                                     num_commands, done_count));
        end
    end

endmodule

`default_nettype wire

// File: all.f
panel_pkg.sv
fillarea_walker.sv
cmd_fillrect.sv
frame_ram.sv
panel_fill_top.sv
tb_clock_gen.sv
tb_panel_fill.sv

// File: Bender.yml
package:
  name: panel_fill

sources:
  - panel_pkg.sv
  - fillarea_walker.sv
  - cmd_fillrect.sv
  - frame_ram.sv
  - panel_fill_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_panel_fill.sv
